/* commit_trace.f */
common/trace_pkg.sv
common/axil_pkg.sv
trace/csr_snapshot_table.sv
trace/store_tracker.sv
trace/commit_monitor.sv
src/perf_counters.sv
src/perf_axil_slave.sv
src/trace_top.sv
test/trace_properties.sv
test/trace_tb.sv

/* Makefile */
SRCS := $(shell cat commit_trace.f)

obj_dir/Vtrace_tb: commit_trace.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module trace_tb -f commit_trace.f -o Vtrace_tb

run: obj_dir/Vtrace_tb
	./obj_dir/Vtrace_tb > sim.log 2>&1; cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* test/trace_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_tb import trace_pkg::*; import axil_pkg::*; ();

    localparam int cw = 2;

    logic clk;
    logic rst;
    dec_slot_t dec [cw];
    csr_snap_t csr_now;
    cmt_slot_t cmt [cw];
    csr_wr_t   csr_wr;
    dc_req_t   dc_req;
    dc_resp_t  dc_resp;
    perf_evt_t evt;
    logic            cmt_valid [cw];
    logic [xlen-1:0] cmt_pc    [cw];
    logic [31:0]     cmt_ir    [cw];
    logic            cmt_exc   [cw];
    csr_snap_t       cmt_csr;
    logic            gpr_we    [cw];
    logic [5:0]      gpr_addr  [cw];
    logic [xlen-1:0] gpr_value [cw];
    logic            csr_we;
    logic [11:0]     csr_addr;
    logic [xlen-1:0] csr_value;
    logic [7:0]      mem_size;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_value;
    axil_aw_t aw;
    logic     aw_valid;
    logic     aw_ready;
    axil_w_t  w;
    logic     w_valid;
    logic     w_ready;
    axil_b_t  b;
    logic     b_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     ar_ready;
    axil_r_t  r;
    logic     r_valid;
    logic     r_ready;

    trace_top #(.cmt_width(cw), .cnt_base('0)) i_dut (.*);

    logic [31:0] lfsr = 32'h71d9_307f;
    csr_snap_t   sh_snap  [128]; // CSRs seen at the last decode of each id
    logic        sh_known [128];
    logic        sh_live  [8];
    logic [63:0] sh_addr  [8];
    logic [63:0] sh_data  [8];
    logic [7:0]  sh_size  [8];
    logic [63:0] sh_cnt   [n_cnt];
    logic        chk_next;      // outputs due for checking at the next edge
    cmt_slot_t   exp_cmt  [cw];
    logic        exp_snap_known;
    csr_snap_t   exp_snap;
    csr_wr_t     exp_csr;
    logic [7:0]  exp_mem_size;
    logic [63:0] exp_mem_addr;
    logic [63:0] exp_mem_value;
    string       test_name;
    int          test_errs;
    int          tests_pass;
    int          tests_fail;
    logic [11:0] alias_list [6] = '{12'h100, 12'h104, 12'h144, 12'hc00, 12'hc01, 12'hc02};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] rnd(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] csr_alias(input logic [11:0] a);
        case (a)
            12'h100, 12'h104, 12'h144: return a + 12'h200;
            12'hc00, 12'hc01, 12'hc02: return a - 12'h100;
            default: return a;
        endcase
    endfunction

    function automatic logic [63:0] store_align(input logic [63:0] d, input logic [7:0] s);
        for (int i = 0; i < 8; i++) begin
            if (s[i]) return d >> (8 * i);
        end
        return d;
    endfunction

    function automatic logic [7:0] store_size(input logic [7:0] s);
        logic [7:0] n;
        n = 8'd0;
        for (int i = 0; i < 8; i++) begin
            n = n + {7'd0, s[i]};
        end
        return n;
    endfunction

    function automatic logic gpr_write(input cmt_slot_t s);
        return s.valid && (s.rd != 6'd0) && !s.exc;
    endfunction

    // shadow counters, indices in address order
    task automatic count_events(input perf_evt_t e, input dc_req_t q);
        if (e.be_redir) begin
            sh_cnt[0] += 64'd1;
            if (e.redir_kind == redir_branch) sh_cnt[2] += 64'd1;
            if (e.redir_kind == redir_jal) sh_cnt[3] += 64'd1;
            if (e.redir_kind == redir_jalr) sh_cnt[4] += 64'd1;
        end else if (e.fe_redir) begin
            sh_cnt[1] += 64'd1;
        end
        if (e.icmiss) sh_cnt[5] += 64'd1;
        if (e.dcmiss) sh_cnt[6] += 64'd1;
        if (e.itmiss) sh_cnt[7] += 64'd1;
        if (e.dtmiss) sh_cnt[8] += 64'd1;
        if (q.valid && q.strb == 8'd0) sh_cnt[9] += 64'd1;
        if (q.valid && q.strb != 8'd0) sh_cnt[10] += 64'd1;
    endtask

    task automatic expect_eq(input string what, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %0h actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic next_cycle();
        next_edge();
        for (int i = 0; i < cw; i++) begin
            dec[i] = '0;
            cmt[i] = '0;
        end
        csr_wr  = '0;
        dc_req  = '0;
        dc_resp = '0;
        evt     = '0;
    endtask

    // record what the inputs of this cycle must produce, then update the shadows
    task automatic apply_cycle();
        for (int i = 0; i < cw; i++) begin
            exp_cmt[i] = cmt[i];
        end
        exp_snap_known = sh_known[cmt[0].opid];
        exp_snap = sh_snap[cmt[0].opid];
        for (int i = 0; i < cw; i++) begin
            if (dec[i].valid) begin
                sh_snap[dec[i].opid]  = csr_now;
                sh_known[dec[i].opid] = 1'b1;
            end
        end
        exp_csr = csr_wr;
        exp_csr.addr = csr_alias(csr_wr.addr);
        exp_mem_size = 8'd0;
        if (dc_resp.valid && dc_resp.hit && sh_live[dc_resp.tag]) begin
            exp_mem_size  = sh_size[dc_resp.tag];
            exp_mem_addr  = sh_addr[dc_resp.tag];
            exp_mem_value = sh_data[dc_resp.tag];
        end
        if (dc_resp.valid && dc_resp.hit) sh_live[dc_resp.tag] = 1'b0;
        if (dc_req.valid) begin
            sh_live[dc_req.tag] = (dc_req.strb != 8'd0);
            sh_addr[dc_req.tag] = dc_req.addr;
            sh_data[dc_req.tag] = store_align(dc_req.wdata, dc_req.strb);
            sh_size[dc_req.tag] = store_size(dc_req.strb);
        end
        count_events(evt, dc_req);
        chk_next = 1'b1;
    endtask

    always @(posedge clk) begin
        #1;
        if (chk_next) begin
            for (int i = 0; i < cw; i++) begin
                expect_eq("cmt_valid", exp_cmt[i].valid, cmt_valid[i]);
                if (exp_cmt[i].valid) begin
                    expect_eq("cmt_pc", exp_cmt[i].pc, cmt_pc[i]);
                    expect_eq("cmt_ir", exp_cmt[i].ir, cmt_ir[i]);
                    expect_eq("cmt_exc", exp_cmt[i].exc, cmt_exc[i]);
                end
                expect_eq("gpr_we", gpr_write(exp_cmt[i]), gpr_we[i]);
                if (gpr_write(exp_cmt[i])) begin
                    expect_eq("gpr_addr", exp_cmt[i].rd, gpr_addr[i]);
                    expect_eq("gpr_value", exp_cmt[i].rd_value, gpr_value[i]);
                end
            end
            if (exp_cmt[0].valid && exp_snap_known) expect_eq("cmt_csr", exp_snap, cmt_csr);
            expect_eq("csr_we", exp_csr.valid, csr_we);
            if (exp_csr.valid) begin
                expect_eq("csr_addr", exp_csr.addr, csr_addr);
                expect_eq("csr_value", exp_csr.value, csr_value);
            end
            expect_eq("mem_size", exp_mem_size, mem_size);
            if (exp_mem_size != 8'd0) begin
                expect_eq("mem_addr", exp_mem_addr, mem_addr);
                expect_eq("mem_value", exp_mem_value, mem_value);
            end
            chk_next = 1'b0;
        end
    end

    task automatic random_commit(input logic csr_on, input logic [11:0] addr);
        next_cycle();
        csr_now = {rnd(64), rnd(64), rnd(64), rnd(64)};
        for (int i = 0; i < cw; i++) begin
            dec[i].valid    = rnd(1) != 0;
            dec[i].opid     = 7'(rnd(4)); // small id range forces reuse
            cmt[i].valid    = rnd(2) != 0;
            cmt[i].opid     = 7'(rnd(4));
            cmt[i].pc       = rnd(64);
            cmt[i].ir       = 32'(rnd(32));
            cmt[i].rd       = 6'(rnd(3));
            cmt[i].rd_value = rnd(64);
            cmt[i].exc      = rnd(2) == 0;
        end
        csr_wr.valid = csr_on;
        csr_wr.addr  = addr;
        csr_wr.value = rnd(64);
        apply_cycle();
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [63:0] data,
                             output axil_resp_e resp);
        int n;
        int delay;
        ar.addr  = addr;
        ar_valid = 1'b1;
        n = 0;
        while (!ar_ready) begin
            next_edge();
            n++;
            if (n > 50) give_up("ar_ready");
        end
        next_edge();
        ar_valid = 1'b0;
        n = 0;
        while (!r_valid) begin
            next_edge();
            n++;
            if (n > 50) give_up("r_valid");
        end
        delay = int'(rnd(2));
        repeat (delay) next_edge();
        r_ready = 1'b1;
        data = r.data;
        resp = r.resp;
        next_edge();
        r_ready = 1'b0;
    endtask

    task automatic axil_write(input logic [31:0] addr, output axil_resp_e resp);
        int n;
        aw.addr  = addr;
        w.data   = rnd(64);
        w.strb   = 8'hff;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        n = 0;
        while (!aw_ready) begin
            next_edge();
            n++;
            if (n > 50) give_up("aw_ready");
        end
        next_edge();
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        n = 0;
        while (!b_valid) begin
            next_edge();
            n++;
            if (n > 50) give_up("b_valid");
        end
        repeat (int'(rnd(2))) next_edge();
        b_ready = 1'b1;
        resp = b.resp;
        next_edge();
        b_ready = 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [63:0] exp_data,
                              input axil_resp_e exp_resp);
        logic [63:0] d;
        axil_resp_e  rs;
        axil_read(addr, d, rs);
        expect_eq("rdata", exp_data, d);
        expect_eq("rresp", exp_resp, rs);
    endtask

    task automatic write_check(input logic [31:0] addr, input axil_resp_e exp_resp);
        axil_resp_e rs;
        axil_write(addr, rs);
        expect_eq("bresp", exp_resp, rs);
        if (exp_resp == resp_okay) sh_cnt[addr[6:3]] = 64'd0;
    endtask

    task automatic read_all();
        for (int i = 0; i < n_cnt; i++) begin
            read_check(32'(i * 8), sh_cnt[i], resp_okay);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        next_cycle();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
            tests_pass++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            tests_fail++;
        end
    endtask

    initial begin
        int ord [8];
        int j;
        int tmp;
        rst = 1'b1;
        chk_next = 1'b0;
        csr_now = '0;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        tests_pass = 0;
        tests_fail = 0;
        for (int i = 0; i < cw; i++) begin
            dec[i] = '0;
            cmt[i] = '0;
        end
        csr_wr = '0;
        dc_req = '0;
        dc_resp = '0;
        evt = '0;
        for (int i = 0; i < 128; i++) sh_known[i] = 1'b0;
        for (int i = 0; i < 8; i++) sh_live[i] = 1'b0;
        for (int i = 0; i < n_cnt; i++) sh_cnt[i] = 64'd0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("snapshots");
        for (int k = 0; k < 16; k += cw) begin
            next_cycle();
            csr_now = {rnd(64), rnd(64), rnd(64), rnd(64)};
            for (int i = 0; i < cw; i++) begin
                dec[i].valid = 1'b1;
                dec[i].opid  = 7'(k + i);
            end
            apply_cycle();
        end
        for (int k = 0; k < 60; k++) random_commit(1'b0, 12'h000);
        end_test();

        start_test("register_deltas");
        for (int k = 0; k < 60; k++) random_commit(rnd(1) != 0, 12'(rnd(12)));
        end_test();

        start_test("csr_alias");
        for (int k = 0; k < 16; k++) random_commit(1'b1, k < 6 ? alias_list[k] : 12'(rnd(12)));
        end_test();

        start_test("store_deltas");
        for (int round = 0; round < 6; round++) begin
            for (int t = 0; t < 8; t++) begin
                next_cycle();
                dc_req.valid = 1'b1;
                dc_req.tag   = 3'(t);
                dc_req.addr  = rnd(64);
                dc_req.wdata = rnd(64);
                dc_req.strb  = (rnd(2) == 0) ? 8'h00 : 8'(rnd(8));
                if (dc_req.strb == 8'h00 && rnd(1) != 0) dc_req.strb = 8'h80;
                apply_cycle();
                ord[t] = t;
            end
            for (int i = 7; i > 0; i--) begin
                j = int'(rnd(3)) % (i + 1);
                tmp = ord[i];
                ord[i] = ord[j];
                ord[j] = tmp;
            end
            for (int t = 0; t < 8; t++) begin
                next_cycle();
                dc_resp.valid = 1'b1;
                dc_resp.tag   = 3'(ord[t]);
                dc_resp.hit   = rnd(2) != 0;
                apply_cycle();
            end
        end
        end_test();

        start_test("counters_axil");
        for (int k = 0; k < 100; k++) begin
            next_cycle();
            evt = perf_evt_t'(rnd(8));
            dc_req.valid = rnd(1) != 0;
            dc_req.tag   = 3'(rnd(3));
            dc_req.strb  = (rnd(1) != 0) ? 8'(rnd(8)) : 8'h00;
            apply_cycle();
        end
        next_cycle();
        read_all();
        write_check(32'h10, resp_okay);
        write_check(32'h48, resp_okay);
        read_all();
        read_check(32'(n_cnt * 8), 64'd0, resp_slverr);
        read_check(32'h0000_0014, 64'd0, resp_slverr);
        write_check(32'(n_cnt * 8), resp_slverr);
        write_check(32'h0000_0003, resp_slverr);
        read_all();
        end_test();

        $display("tests passed %0d failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/trace_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_properties import trace_pkg::*; import axil_pkg::*; (
    input wire logic       clk,
    input wire logic       rst,
    input wire axil_r_t    r,
    input wire logic       r_valid,
    input wire logic       r_ready,
    input wire logic       b_valid,
    input wire logic       b_ready,
    input wire dc_resp_t   dc_resp,
    input wire logic [7:0] mem_size,
    input wire logic       cmt_valid0,
    input wire logic       gpr_we0,
    input wire logic       csr_we
);

    // read response frozen until the host takes it
    assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R channel changed before r_ready");

    assert property (@(posedge clk) disable iff (rst) b_valid && !b_ready |=> b_valid)
        else $error("B channel dropped before b_ready");

    assert property (@(posedge clk) disable iff (rst)
        mem_size != 8'd0 |-> $past(dc_resp.valid && dc_resp.hit))
        else $error("memory delta without a hit response");

    assert property (@(posedge clk) $fell(rst) |->
        !cmt_valid0 && !gpr_we0 && !csr_we && mem_size == 8'd0 && !r_valid && !b_valid)
        else $error("output valid right after reset");

endmodule

bind trace_top trace_properties i_props (
    .clk       (clk),
    .rst       (rst),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .dc_resp   (dc_resp),
    .mem_size  (mem_size),
    .cmt_valid0(cmt_valid[0]),
    .gpr_we0   (gpr_we[0]),
    .csr_we    (csr_we)
);

`default_nettype wire

/* src/trace_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_top import trace_pkg::*; import axil_pkg::*; #(
    parameter int                     cmt_width = 2,
    parameter logic [axil_addr_w-1:0] cnt_base  = '0
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire dec_slot_t dec [cmt_width],
    input  wire csr_snap_t csr_now,
    input  wire cmt_slot_t cmt [cmt_width],
    input  wire csr_wr_t   csr_wr,
    input  wire dc_req_t   dc_req,
    input  wire dc_resp_t  dc_resp,
    input  wire perf_evt_t evt,
    output logic            cmt_valid [cmt_width],
    output logic [xlen-1:0] cmt_pc    [cmt_width],
    output logic [31:0]     cmt_ir    [cmt_width],
    output logic            cmt_exc   [cmt_width],
    output csr_snap_t       cmt_csr,
    output logic            gpr_we    [cmt_width],
    output logic [5:0]      gpr_addr  [cmt_width],
    output logic [xlen-1:0] gpr_value [cmt_width],
    output logic            csr_we,
    output logic [11:0]     csr_addr,
    output logic [xlen-1:0] csr_value,
    output logic [7:0]      mem_size,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_value,
    input  wire axil_aw_t  aw,
    input  wire logic      aw_valid,
    output logic           aw_ready,
    input  wire axil_w_t   w,
    input  wire logic      w_valid,
    output logic           w_ready,
    output axil_b_t        b,
    output logic           b_valid,
    input  wire logic      b_ready,
    input  wire axil_ar_t  ar,
    input  wire logic      ar_valid,
    output logic           ar_ready,
    output axil_r_t        r,
    output logic           r_valid,
    input  wire logic      r_ready
);

    logic [xlen-1:0] cnt [n_cnt];
    logic            clr;
    perf_sel_e       clr_sel;

    commit_monitor #(
        .cmt_width(cmt_width)
    ) i_commit (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .csr_now  (csr_now),
        .cmt      (cmt),
        .csr_wr   (csr_wr),
        .cmt_valid(cmt_valid),
        .cmt_pc   (cmt_pc),
        .cmt_ir   (cmt_ir),
        .cmt_exc  (cmt_exc),
        .cmt_csr  (cmt_csr),
        .gpr_we   (gpr_we),
        .gpr_addr (gpr_addr),
        .gpr_value(gpr_value),
        .csr_we   (csr_we),
        .csr_addr (csr_addr),
        .csr_value(csr_value)
    );

    store_tracker i_store (
        .clk      (clk),
        .rst      (rst),
        .dc_req   (dc_req),
        .dc_resp  (dc_resp),
        .mem_size (mem_size),
        .mem_addr (mem_addr),
        .mem_value(mem_value)
    );

    perf_counters i_counters (
        .clk    (clk),
        .rst    (rst),
        .evt    (evt),
        .dc_req (dc_req),
        .clr    (clr),
        .clr_sel(clr_sel),
        .cnt    (cnt)
    );

    perf_axil_slave #(
        .cnt_base(cnt_base)
    ) i_axil (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w       (w),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .b       (b),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .ar      (ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .cnt     (cnt),
        .clr     (clr),
        .clr_sel (clr_sel)
    );

endmodule

`default_nettype wire

/* src/perf_axil_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module perf_axil_slave import trace_pkg::*; import axil_pkg::*; #(
    parameter logic [axil_addr_w-1:0] cnt_base = '0
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire axil_aw_t aw,
    input  wire logic     aw_valid,
    output logic          aw_ready,
    input  wire axil_w_t  w,
    input  wire logic     w_valid,
    output logic          w_ready,
    output axil_b_t       b,
    output logic          b_valid,
    input  wire logic     b_ready,
    input  wire axil_ar_t ar,
    input  wire logic     ar_valid,
    output logic          ar_ready,
    output axil_r_t       r,
    output logic          r_valid,
    input  wire logic     r_ready,
    input  wire logic [xlen-1:0] cnt [n_cnt],
    output logic          clr,
    output perf_sel_e     clr_sel
);

    typedef enum logic [1:0] {
        st_idle,
        st_read_resp,
        st_write_resp
    } state_e;

    state_e state;

    logic [axil_addr_w-1:0] rd_off;
    logic [axil_addr_w-1:0] wr_off;
    logic                   rd_ok;
    logic                   wr_ok;
    logic                   rd_hs;
    logic                   wr_hs;

    assign rd_off = ar.addr - cnt_base;
    assign wr_off = aw.addr - cnt_base;
    // 8-byte aligned and inside the bank
    assign rd_ok = (rd_off[2:0] == 3'd0) && (rd_off[axil_addr_w-1:3] < (axil_addr_w-3)'(n_cnt));
    assign wr_ok = (wr_off[2:0] == 3'd0) && (wr_off[axil_addr_w-1:3] < (axil_addr_w-3)'(n_cnt));

    // AW and W only taken together, reads first
    assign ar_ready = (state == st_idle);
    assign aw_ready = (state == st_idle) && !ar_valid && (aw_valid == w_valid);
    assign w_ready  = aw_ready;

    assign rd_hs = ar_valid && ar_ready;
    assign wr_hs = aw_valid && aw_ready && w_valid;

    assign r_valid = (state == st_read_resp);
    assign b_valid = (state == st_write_resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            clr   <= 1'b0;
        end else begin
            clr <= wr_hs && wr_ok; // write data plays no part
            case (state)
                st_idle: begin
                    if (rd_hs) begin
                        state <= st_read_resp;
                    end else if (wr_hs) begin
                        state <= st_write_resp;
                    end
                end
                st_read_resp: begin
                    if (r_ready) state <= st_idle;
                end
                st_write_resp: begin
                    if (b_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            r.data <= rd_ok ? cnt[rd_off[6:3]] : '0;
            r.resp <= rd_ok ? resp_okay : resp_slverr;
        end
        if (wr_hs) begin
            b.resp  <= wr_ok ? resp_okay : resp_slverr;
            clr_sel <= perf_sel_e'(wr_off[6:3]);
        end
    end

endmodule

`default_nettype wire

/* src/perf_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module perf_counters import trace_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire perf_evt_t evt,
    input  wire dc_req_t   dc_req,
    input  wire logic      clr,
    input  wire perf_sel_e clr_sel,
    output logic [xlen-1:0] cnt [n_cnt]
);

    logic [n_cnt-1:0] inc; // one bit per counter, indexed by perf_sel_e

    always_comb begin
        inc = '0;
        if (evt.be_redir) begin
            inc[cnt_bmisp] = 1'b1;
            case (evt.redir_kind)
                redir_branch: inc[cnt_brmisp] = 1'b1;
                redir_jal:    inc[cnt_jmisp]  = 1'b1;
                redir_jalr:   inc[cnt_jrmisp] = 1'b1;
                default:      ;
            endcase
        end else if (evt.fe_redir) begin
            inc[cnt_fmisp] = 1'b1; // only without a backend redirect
        end
        inc[cnt_icmiss] = evt.icmiss;
        inc[cnt_dcmiss] = evt.dcmiss;
        inc[cnt_itmiss] = evt.itmiss;
        inc[cnt_dtmiss] = evt.dtmiss;
        inc[cnt_loads]  = dc_req.valid && (dc_req.strb == 8'd0);
        inc[cnt_stores] = dc_req.valid && (dc_req.strb != 8'd0);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < n_cnt; i++) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (clr && clr_sel == perf_sel_e'(i)) begin
                cnt[i] <= '0; // host clear beats a same-cycle event
            end else if (inc[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* trace/commit_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_monitor import trace_pkg::*; #(
    parameter int cmt_width = 2
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire dec_slot_t dec [cmt_width],
    input  wire csr_snap_t csr_now,
    input  wire cmt_slot_t cmt [cmt_width],
    input  wire csr_wr_t   csr_wr,
    output logic            cmt_valid [cmt_width],
    output logic [xlen-1:0] cmt_pc    [cmt_width],
    output logic [31:0]     cmt_ir    [cmt_width],
    output logic            cmt_exc   [cmt_width],
    output csr_snap_t       cmt_csr,
    output logic            gpr_we    [cmt_width],
    output logic [5:0]      gpr_addr  [cmt_width],
    output logic [xlen-1:0] gpr_value [cmt_width],
    output logic            csr_we,
    output logic [11:0]     csr_addr,
    output logic [xlen-1:0] csr_value
);

    csr_snap_t   snap_rd;      // CSRs at decode of slot 0
    logic [11:0] csr_addr_map; // alias folded onto machine address

    csr_snapshot_table #(
        .cmt_width(cmt_width)
    ) i_snap (
        .clk    (clk),
        .rst    (rst),
        .dec    (dec),
        .csr_now(csr_now),
        .rd_id  (cmt[0].opid),
        .rd_csr (snap_rd)
    );

    always_comb begin
        csr_addr_map = csr_wr.addr;
        if (csr_wr.addr == 12'h100 || csr_wr.addr == 12'h104 || csr_wr.addr == 12'h144) begin
            csr_addr_map = csr_wr.addr + 12'h200; // sstatus, sie, sip
        end else if (csr_wr.addr >= 12'hc00 && csr_wr.addr <= 12'hc02) begin
            csr_addr_map = csr_wr.addr - 12'h100; // cycle, time, instret
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cmt_width; i++) begin
                cmt_valid[i] <= 1'b0;
                gpr_we[i]    <= 1'b0;
            end
            csr_we <= 1'b0;
        end else begin
            for (int i = 0; i < cmt_width; i++) begin
                cmt_valid[i] <= cmt[i].valid;
                // excepting ops leave the register file alone
                gpr_we[i]    <= cmt[i].valid && (cmt[i].rd != 6'd0) && !cmt[i].exc;
            end
            csr_we <= csr_wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < cmt_width; i++) begin
            cmt_pc[i]    <= cmt[i].pc;
            cmt_ir[i]    <= cmt[i].ir;
            cmt_exc[i]   <= cmt[i].exc;
            gpr_addr[i]  <= cmt[i].rd;
            gpr_value[i] <= cmt[i].rd_value;
        end
        cmt_csr   <= snap_rd;
        csr_addr  <= csr_addr_map;
        csr_value <= csr_wr.value;
    end

endmodule

`default_nettype wire

/* trace/store_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module store_tracker import trace_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire dc_req_t  dc_req,
    input  wire dc_resp_t dc_resp,
    output logic [7:0]      mem_size,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_value
);

    localparam int n_tag = 2**dc_tag_w;

    logic [xlen-1:0] st_addr [n_tag];
    logic [xlen-1:0] st_data [n_tag]; // data moved down to byte 0
    logic [7:0]      st_size [n_tag]; // bytes written
    logic            st_live [n_tag]; // tag currently holds a store
    logic [2:0]      lsb;             // lowest enabled byte lane
    logic            is_store;
    logic            release_hit;

    assign is_store    = dc_req.valid && (dc_req.strb != 8'd0);
    assign release_hit = dc_resp.valid && dc_resp.hit && st_live[dc_resp.tag];

    always_comb begin
        lsb = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (dc_req.strb[i]) lsb = 3'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_size <= 8'd0;
            for (int i = 0; i < n_tag; i++) begin
                st_live[i] <= 1'b0;
            end
        end else begin
            mem_size <= release_hit ? st_size[dc_resp.tag] : 8'd0;
            if (dc_resp.valid && dc_resp.hit) begin
                st_live[dc_resp.tag] <= 1'b0;
            end
            if (dc_req.valid) begin
                st_live[dc_req.tag] <= is_store; // a load reusing the tag kills it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            st_addr[dc_req.tag] <= dc_req.addr;
            st_data[dc_req.tag] <= dc_req.wdata >> {lsb, 3'b000};
            st_size[dc_req.tag] <= 8'($countones(dc_req.strb));
        end
        mem_addr  <= st_addr[dc_resp.tag];
        mem_value <= st_data[dc_resp.tag];
    end

endmodule

`default_nettype wire

/* trace/csr_snapshot_table.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_snapshot_table import trace_pkg::*; #(
    parameter int cmt_width = 2
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire dec_slot_t   dec [cmt_width],
    input  wire csr_snap_t   csr_now,
    input  wire logic [opid_w-1:0] rd_id,
    output csr_snap_t        rd_csr
);

    csr_snap_t snap [2**opid_w]; // one entry per op id

    // every decoded op in the bundle sees the same CSR state
    always_ff @(posedge clk) begin
        for (int i = 0; i < cmt_width; i++) begin
            if (!rst && dec[i].valid) begin
                snap[dec[i].opid] <= csr_now;
            end
        end
    end

    // read before the edge, so a same-cycle decode of rd_id is not seen
    assign rd_csr = snap[rd_id];

endmodule

`default_nettype wire

/* common/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 64;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [axil_addr_w-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [axil_data_w-1:0]   data;
        logic [axil_data_w/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [axil_addr_w-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [axil_data_w-1:0] data;
        axil_resp_e             resp;
    } axil_r_t;

endpackage

`default_nettype wire

/* common/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    localparam int xlen     = 64;
    localparam int opid_w   = 7;   // 128 ops in flight
    localparam int dc_tag_w = 3;   // 8 outstanding dcache requests
    localparam int n_cnt    = 11;  // performance counters in the bank

    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mepc;
    } csr_snap_t;

    typedef struct packed {
        logic              valid;
        logic [opid_w-1:0] opid;
    } dec_slot_t;

    typedef struct packed {
        logic              valid;
        logic [opid_w-1:0] opid;
        logic [xlen-1:0]   pc;
        logic [31:0]       ir;
        logic [5:0]        rd;       // logical destination, 0 means none
        logic [xlen-1:0]   rd_value; // value written to rd
        logic              exc;      // op raised an exception
    } cmt_slot_t;

    typedef struct packed {
        logic            valid;
        logic [11:0]     addr;
        logic [xlen-1:0] value;
    } csr_wr_t;

    typedef struct packed {
        logic                valid;
        logic [dc_tag_w-1:0] tag;
        logic [xlen-1:0]     addr;
        logic [xlen-1:0]     wdata;
        logic [7:0]          strb;  // non-zero for a store
    } dc_req_t;

    typedef struct packed {
        logic                valid;
        logic [dc_tag_w-1:0] tag;
        logic                hit;
    } dc_resp_t;

    typedef enum logic [1:0] {
        redir_none,
        redir_branch,
        redir_jal,
        redir_jalr
    } redir_kind_e;

    typedef struct packed {
        logic        fe_redir;
        logic        be_redir;
        redir_kind_e redir_kind; // what the backend redirect came from
        logic        icmiss;
        logic        dcmiss;
        logic        itmiss;
        logic        dtmiss;
    } perf_evt_t;

    // counter order matches the AXI address map, 8 bytes apart
    typedef enum logic [3:0] {
        cnt_bmisp,
        cnt_fmisp,
        cnt_brmisp,
        cnt_jmisp,
        cnt_jrmisp,
        cnt_icmiss,
        cnt_dcmiss,
        cnt_itmiss,
        cnt_dtmiss,
        cnt_loads,
        cnt_stores
    } perf_sel_e;

endpackage

`default_nettype wire
